// ==== common/fight_pkg.sv ====
package fight_pkg;

  // ##########################################################################
  // basic types.
  // ##########################################################################

  typedef logic [9:0] coord_t;  // screen coordinate.
  typedef logic [7:0] health_t;

  localparam int PHASE_W = 5;
  typedef logic [PHASE_W-1:0] phase_t;

  typedef enum logic [3:0] {
    ST_IDLE      = 4'd0,
    ST_FORWARD   = 4'd1,
    ST_BACKWARD  = 4'd2,
    ST_ATK_START = 4'd3,
    ST_ATK_HIT   = 4'd4,
    ST_ATK_PULL  = 4'd5
  } player_state_t;

  localparam logic SIDE_LEFT  = 1'b0;
  localparam logic SIDE_RIGHT = 1'b1;  // faces left toward the other player.

  // ##########################################################################
  // arena and movement.
  // ##########################################################################

  localparam coord_t POS_Y         = 10'd170;
  localparam coord_t START_X_LEFT  = 10'd210;
  localparam coord_t START_X_RIGHT = 10'd420;
  localparam coord_t X_MIN         = 10'd50;
  localparam coord_t X_MAX         = 10'd490;

  localparam coord_t STEP_FWD  = 10'd3;
  localparam coord_t STEP_BACK = 10'd2;

  // attack phase lengths in cycles.
  localparam phase_t ATK_START_LEN = 5'd5;
  localparam phase_t ATK_HIT_LEN   = 5'd2;
  localparam phase_t ATK_PULL_LEN  = 5'd16;

  // box offsets from posx / posy.
  localparam coord_t SPRITE_W  = 10'd150;
  localparam coord_t HURT_X_LO = 10'd37;
  localparam coord_t HURT_X_HI = 10'd86;
  localparam coord_t HURT_H    = 10'd150;
  localparam coord_t HIT_X_LO  = 10'd35;
  localparam coord_t HIT_X_HI  = 10'd113;
  localparam coord_t HIT_Y_LO  = 10'd24;
  localparam coord_t HIT_Y_HI  = 10'd57;

  localparam health_t HEALTH_FULL = 8'd100;

endpackage

// ==== common/fight_regs_pkg.sv ====
package fight_regs_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // ##########################################################################
  // register map.
  // ##########################################################################

  localparam apb_addr_t ADDR_CTRL   = 8'h00;
  localparam apb_addr_t ADDR_DAMAGE = 8'h04;
  localparam apb_addr_t ADDR_HEALTH = 8'h08;  // read only.
  localparam apb_addr_t ADDR_STATUS = 8'h0C;  // read only.
  localparam apb_addr_t ADDR_POS    = 8'h10;  // read only.

  // field positions.
  localparam int CTRL_RUN_BIT       = 0;
  localparam int CTRL_NEW_ROUND_BIT = 1;  // self clearing.
  localparam int DAMAGE_LSB         = 0;
  localparam int HEALTH_L_LSB       = 0;
  localparam int HEALTH_R_LSB       = 8;
  localparam int STATUS_KO_L_BIT    = 0;
  localparam int STATUS_KO_R_BIT    = 1;
  localparam int POS_L_LSB          = 0;
  localparam int POS_R_LSB          = 16;

  // reset values.
  localparam apb_data_t   CTRL_RESET   = 32'h0000_0001;
  localparam logic [7:0]  DAMAGE_RESET = 8'd10;

endpackage

// ==== player/player.sv ====
module player import fight_pkg::*; #(
  parameter logic SIDE = SIDE_LEFT
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          play,
  input  logic          left,
  input  logic          right,
  input  logic          attack,
  output coord_t        posx,
  output player_state_t state,
  output logic          hit_frame,
  output coord_t        hit_x_lo,
  output coord_t        hit_x_hi,
  output coord_t        hit_y_lo,
  output coord_t        hit_y_hi,
  output coord_t        hurt_x_lo,
  output coord_t        hurt_x_hi,
  output coord_t        hurt_y_lo,
  output coord_t        hurt_y_hi
);

  player_state_t state_next;
  phase_t        timer;
  coord_t        pos_step;
  coord_t        pos_next;

  // ##########################################################################
  // state machine.
  // ##########################################################################

  always_comb begin
    state_next = state;
    if (!play) begin
      state_next = ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_FORWARD, ST_BACKWARD: begin
          if (attack) begin
            state_next = ST_ATK_START;
          end else if (left && right) begin
            state_next = ST_BACKWARD;  // both pressed backs off.
          end else if (left) begin
            state_next = (SIDE == SIDE_RIGHT) ? ST_FORWARD : ST_BACKWARD;
          end else if (right) begin
            state_next = (SIDE == SIDE_RIGHT) ? ST_BACKWARD : ST_FORWARD;
          end else begin
            state_next = ST_IDLE;
          end
        end
        ST_ATK_START: begin
          if (timer == ATK_START_LEN - 1'b1) state_next = ST_ATK_HIT;
        end
        ST_ATK_HIT: begin
          if (timer == ATK_HIT_LEN - 1'b1) state_next = ST_ATK_PULL;
        end
        ST_ATK_PULL: begin
          if (timer == ATK_PULL_LEN - 1'b1) state_next = ST_IDLE;
        end
        default: state_next = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
      timer <= '0;
    end else begin
      state <= state_next;
      // restart on every phase entry.
      timer <= (state_next != state) ? '0 : timer + 1'b1;
    end
  end

  assign hit_frame = (state == ST_ATK_HIT) && (timer == '0);

  // ##########################################################################
  // position.
  // ##########################################################################

  always_comb begin
    pos_step = posx;
    if (play && state == ST_FORWARD) begin
      pos_step = (SIDE == SIDE_LEFT) ? posx + STEP_FWD : posx - STEP_FWD;
    end else if (play && state == ST_BACKWARD) begin
      pos_step = (SIDE == SIDE_LEFT) ? posx - STEP_BACK : posx + STEP_BACK;
    end
    // clamp after the step.
    if (pos_step < X_MIN) begin
      pos_next = X_MIN;
    end else if (pos_step > X_MAX) begin
      pos_next = X_MAX;
    end else begin
      pos_next = pos_step;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      posx <= (SIDE == SIDE_LEFT) ? START_X_LEFT : START_X_RIGHT;
    end else begin
      posx <= pos_next;
    end
  end

  // boxes. the hitbox mirrors about the sprite width for the right side.
  assign hit_x_lo  = (SIDE == SIDE_LEFT) ? posx + HIT_X_LO : posx + SPRITE_W - HIT_X_HI;
  assign hit_x_hi  = (SIDE == SIDE_LEFT) ? posx + HIT_X_HI : posx + SPRITE_W - HIT_X_LO;
  assign hit_y_lo  = POS_Y + HIT_Y_LO;
  assign hit_y_hi  = POS_Y + HIT_Y_HI;
  assign hurt_x_lo = posx + HURT_X_LO;
  assign hurt_x_hi = posx + HURT_X_HI;
  assign hurt_y_lo = POS_Y;
  assign hurt_y_hi = POS_Y + HURT_H;

endmodule

// ==== logic/hit_detect.sv ====
module hit_detect import fight_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   hit_frame_l,
  input  logic   hit_frame_r,
  input  coord_t hit_l_x_lo,
  input  coord_t hit_l_x_hi,
  input  coord_t hit_l_y_lo,
  input  coord_t hit_l_y_hi,
  input  coord_t hurt_r_x_lo,
  input  coord_t hurt_r_x_hi,
  input  coord_t hurt_r_y_lo,
  input  coord_t hurt_r_y_hi,
  input  coord_t hit_r_x_lo,
  input  coord_t hit_r_x_hi,
  input  coord_t hit_r_y_lo,
  input  coord_t hit_r_y_hi,
  input  coord_t hurt_l_x_lo,
  input  coord_t hurt_l_x_hi,
  input  coord_t hurt_l_y_lo,
  input  coord_t hurt_l_y_hi,
  output logic   hit_on_l,
  output logic   hit_on_r
);

  logic strike_r;  // left hits right.
  logic strike_l;  // right hits left.

  // inclusive interval overlap.
  function automatic logic overlap(coord_t a_lo, coord_t a_hi, coord_t b_lo, coord_t b_hi);
    return (a_lo <= b_hi) && (b_lo <= a_hi);
  endfunction

  assign strike_r = hit_frame_l
                 && overlap(hit_l_x_lo, hit_l_x_hi, hurt_r_x_lo, hurt_r_x_hi)
                 && overlap(hit_l_y_lo, hit_l_y_hi, hurt_r_y_lo, hurt_r_y_hi);

  assign strike_l = hit_frame_r
                 && overlap(hit_r_x_lo, hit_r_x_hi, hurt_l_x_lo, hurt_l_x_hi)
                 && overlap(hit_r_y_lo, hit_r_y_hi, hurt_l_y_lo, hurt_l_y_hi);

  // pulses name the struck player. both may fire together.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hit_on_l <= 1'b0;
      hit_on_r <= 1'b0;
    end else begin
      hit_on_l <= strike_l;
      hit_on_r <= strike_r;
    end
  end

endmodule

// ==== logic/health_keeper.sv ====
module health_keeper import fight_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    run,
  input  logic    new_round,
  input  health_t damage,
  input  logic    hit_on_l,
  input  logic    hit_on_r,
  output health_t health_l,
  output health_t health_r,
  output logic    ko_l,
  output logic    ko_r,
  output logic    play
);

  health_t health_l_next;
  health_t health_r_next;

  // saturating subtract.
  always_comb begin
    health_l_next = health_l;
    health_r_next = health_r;
    if (hit_on_l) health_l_next = (health_l > damage) ? health_l - damage : '0;
    if (hit_on_r) health_r_next = (health_r > damage) ? health_r - damage : '0;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      health_l <= HEALTH_FULL;
      health_r <= HEALTH_FULL;
      ko_l     <= 1'b0;
      ko_r     <= 1'b0;
    end else if (new_round) begin
      health_l <= HEALTH_FULL;
      health_r <= HEALTH_FULL;
      ko_l     <= 1'b0;
      ko_r     <= 1'b0;
    end else begin
      health_l <= health_l_next;
      health_r <= health_r_next;
      // sticky and set with the last blow.
      ko_l     <= ko_l | (health_l_next == '0);
      ko_r     <= ko_r | (health_r_next == '0);
    end
  end

  assign play = run & ~ko_l & ~ko_r;

endmodule

// ==== logic/fight_regs.sv ====
module fight_regs import fight_pkg::*, fight_regs_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  input  health_t   health_l,
  input  health_t   health_r,
  input  logic      ko_l,
  input  logic      ko_r,
  input  coord_t    posx_l,
  input  coord_t    posx_r,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      run,
  output logic      new_round,
  output health_t   damage
);

  logic access;
  logic addr_hit;
  logic addr_ro;
  logic wr_en;

  // ##########################################################################
  // decode and read mux.
  // ##########################################################################

  always_comb begin
    addr_hit = 1'b1;
    addr_ro  = 1'b0;
    prdata   = '0;
    case (paddr)
      ADDR_CTRL: begin
        prdata[CTRL_RUN_BIT] = run;  // new_round always reads 0.
      end
      ADDR_DAMAGE: begin
        prdata[DAMAGE_LSB +: $bits(health_t)] = damage;
      end
      ADDR_HEALTH: begin
        addr_ro = 1'b1;
        prdata[HEALTH_L_LSB +: $bits(health_t)] = health_l;
        prdata[HEALTH_R_LSB +: $bits(health_t)] = health_r;
      end
      ADDR_STATUS: begin
        addr_ro = 1'b1;
        prdata[STATUS_KO_L_BIT] = ko_l;
        prdata[STATUS_KO_R_BIT] = ko_r;
      end
      ADDR_POS: begin
        addr_ro = 1'b1;
        prdata[POS_L_LSB +: $bits(coord_t)] = posx_l;
        prdata[POS_R_LSB +: $bits(coord_t)] = posx_r;
      end
      default: addr_hit = 1'b0;
    endcase
  end

  assign access  = psel & penable;
  assign pready  = 1'b1;  // zero wait states.
  assign pslverr = access & (~addr_hit | (pwrite & addr_ro));
  assign wr_en   = access & pwrite & ~pslverr;

  // ##########################################################################
  // writable registers.
  // ##########################################################################

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run       <= CTRL_RESET[CTRL_RUN_BIT];
      new_round <= 1'b0;
      damage    <= DAMAGE_RESET;
    end else begin
      new_round <= wr_en && (paddr == ADDR_CTRL) && pwdata[CTRL_NEW_ROUND_BIT];
      if (wr_en && paddr == ADDR_CTRL) run <= pwdata[CTRL_RUN_BIT];
      if (wr_en && paddr == ADDR_DAMAGE) begin
        damage <= pwdata[DAMAGE_LSB +: $bits(health_t)];
      end
    end
  end

endmodule

// ==== logic/fight_top.sv ====
module fight_top import fight_pkg::*, fight_regs_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  input  logic      left_l,
  input  logic      right_l,
  input  logic      attack_l,
  input  logic      left_r,
  input  logic      right_r,
  input  logic      attack_r
);

  logic          run, new_round, play;
  health_t       damage, health_l, health_r;
  logic          ko_l, ko_r;
  logic          hit_on_l, hit_on_r;
  coord_t        posx_l, posx_r;
  player_state_t state_l, state_r;
  logic          hit_frame_l, hit_frame_r;
  coord_t        hit_l_x_lo, hit_l_x_hi, hit_l_y_lo, hit_l_y_hi;
  coord_t        hurt_l_x_lo, hurt_l_x_hi, hurt_l_y_lo, hurt_l_y_hi;
  coord_t        hit_r_x_lo, hit_r_x_hi, hit_r_y_lo, hit_r_y_hi;
  coord_t        hurt_r_x_lo, hurt_r_x_hi, hurt_r_y_lo, hurt_r_y_hi;

  player #(.SIDE(SIDE_LEFT)) i_player_l (
    .clk, .rst, .play, .left(left_l), .right(right_l), .attack(attack_l),
    .posx(posx_l), .state(state_l), .hit_frame(hit_frame_l),
    .hit_x_lo(hit_l_x_lo), .hit_x_hi(hit_l_x_hi), .hit_y_lo(hit_l_y_lo), .hit_y_hi(hit_l_y_hi),
    .hurt_x_lo(hurt_l_x_lo), .hurt_x_hi(hurt_l_x_hi),
    .hurt_y_lo(hurt_l_y_lo), .hurt_y_hi(hurt_l_y_hi)
  );

  player #(.SIDE(SIDE_RIGHT)) i_player_r (
    .clk, .rst, .play, .left(left_r), .right(right_r), .attack(attack_r),
    .posx(posx_r), .state(state_r), .hit_frame(hit_frame_r),
    .hit_x_lo(hit_r_x_lo), .hit_x_hi(hit_r_x_hi), .hit_y_lo(hit_r_y_lo), .hit_y_hi(hit_r_y_hi),
    .hurt_x_lo(hurt_r_x_lo), .hurt_x_hi(hurt_r_x_hi),
    .hurt_y_lo(hurt_r_y_lo), .hurt_y_hi(hurt_r_y_hi)
  );

  hit_detect i_hit_detect (
    .clk, .rst, .hit_frame_l, .hit_frame_r,
    .hit_l_x_lo, .hit_l_x_hi, .hit_l_y_lo, .hit_l_y_hi,
    .hurt_r_x_lo, .hurt_r_x_hi, .hurt_r_y_lo, .hurt_r_y_hi,
    .hit_r_x_lo, .hit_r_x_hi, .hit_r_y_lo, .hit_r_y_hi,
    .hurt_l_x_lo, .hurt_l_x_hi, .hurt_l_y_lo, .hurt_l_y_hi,
    .hit_on_l, .hit_on_r
  );

  health_keeper i_health_keeper (
    .clk, .rst, .run, .new_round, .damage, .hit_on_l, .hit_on_r,
    .health_l, .health_r, .ko_l, .ko_r, .play
  );

  fight_regs i_fight_regs (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .health_l, .health_r, .ko_l, .ko_r, .posx_l, .posx_r,
    .prdata, .pready, .pslverr, .run, .new_round, .damage
  );

endmodule

// ==== verif/fight_model.svh ====
`ifndef FIGHT_MODEL_SVH
`define FIGHT_MODEL_SVH

// ############################################################################
// reference model of movement, box overlap and damage.
// ############################################################################

// screen position after k move cycles with a clamp after every step.
function automatic coord_t step_position(coord_t x, logic side, logic l, logic r, int k);
  int pos;
  int step;
  pos  = int'(x);
  step = 0;
  if (l && r) begin
    step = (side == SIDE_LEFT) ? -int'(STEP_BACK) : int'(STEP_BACK);  // backs off.
  end else if (l) begin
    step = (side == SIDE_LEFT) ? -int'(STEP_BACK) : -int'(STEP_FWD);
  end else if (r) begin
    step = (side == SIDE_LEFT) ? int'(STEP_FWD) : int'(STEP_BACK);
  end
  for (int i = 0; i < k; i++) begin
    pos = pos + step;
    if (pos < int'(X_MIN)) pos = int'(X_MIN);
    else if (pos > int'(X_MAX)) pos = int'(X_MAX);
  end
  return coord_t'(pos);
endfunction

// does the attacker's hitbox touch the defender's hurtbox.
function automatic bit boxes_overlap(coord_t atk_x, logic atk_side, coord_t def_x);
  int hit_lo;
  int hit_hi;
  int hurt_lo;
  int hurt_hi;
  bit y_ok;
  if (atk_side == SIDE_LEFT) begin
    hit_lo = int'(atk_x) + int'(HIT_X_LO);
    hit_hi = int'(atk_x) + int'(HIT_X_HI);
  end else begin
    // mirrored about the sprite width.
    hit_lo = int'(atk_x) + int'(SPRITE_W) - int'(HIT_X_HI);
    hit_hi = int'(atk_x) + int'(SPRITE_W) - int'(HIT_X_LO);
  end
  hurt_lo = int'(def_x) + int'(HURT_X_LO);
  hurt_hi = int'(def_x) + int'(HURT_X_HI);
  // both players stand on the same floor line.
  y_ok = (int'(POS_Y) + int'(HIT_Y_LO) <= int'(POS_Y) + int'(HURT_H))
      && (int'(POS_Y) <= int'(POS_Y) + int'(HIT_Y_HI));
  return y_ok && (hit_lo <= hurt_hi) && (hurt_lo <= hit_hi);
endfunction

// health after one attack with a floor at zero.
function automatic health_t apply_damage(health_t h, health_t dmg, bit landed);
  int rest;
  rest = int'(h);
  if (landed) rest = rest - int'(dmg);
  if (rest < 0) rest = 0;
  return health_t'(rest);
endfunction

`endif

// ==== verif/fight_tb.sv ====
module fight_tb import fight_pkg::*, fight_regs_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  logic      clk;
  logic      rst;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      left_l, right_l, attack_l;
  logic      left_r, right_r, attack_r;
  integer    seed;

  `include "fight_model.svh"

  fight_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ##########################################################################
  // failure reporting and compares.
  // ##########################################################################

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_health(input string name, input health_t got, input health_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ##########################################################################
  // APB and pad drivers.
  // ##########################################################################

  task automatic bus_transfer(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              input logic exp_err, output apb_data_t rdata);
    int n;
    @(negedge clk);
    {psel, penable, pwrite, paddr, pwdata} = {1'b1, 1'b0, write, addr, wdata};
    @(negedge clk);
    penable = 1'b1;
    #1;
    n = 0;
    while (!pready) begin
      if (n == 8) report_failure("APB access cycle saw no pready within 8 cycles");
      @(negedge clk);
      #1;
      n++;
    end
    rdata = prdata;
    check_data("pslverr", apb_data_t'(pslverr), apb_data_t'(exp_err));
    @(negedge clk);
    {psel, penable, pwrite} = 3'b000;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_data_t unused;
    bus_transfer(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
    bus_transfer(1'b0, addr, '0, exp_err, data);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (i_dut.state_l != ST_IDLE || i_dut.state_r != ST_IDLE) begin
      if (n == 40) report_failure("players did not return to idle within 40 cycles");
      @(negedge clk);
      n++;
    end
  endtask

  // pads held for a number of rising edges and then released.
  task automatic hold_pads(input logic l_l, input logic r_l, input logic a_l,
                           input logic l_r, input logic r_r, input logic a_r, input int cycles);
    @(negedge clk);
    {left_l, right_l, attack_l, left_r, right_r, attack_r} = {l_l, r_l, a_l, l_r, r_r, a_r};
    repeat (cycles) @(negedge clk);
    {left_l, right_l, attack_l, left_r, right_r, attack_r} = 6'b0;
    wait_idle();
  endtask

  task automatic read_positions(input coord_t exp_pl, input coord_t exp_pr);
    apb_data_t rdata;
    apb_read(ADDR_POS, 1'b0, rdata);
    check_coord("posx_l", rdata[POS_L_LSB +: $bits(coord_t)], exp_pl);
    check_coord("posx_r", rdata[POS_R_LSB +: $bits(coord_t)], exp_pr);
  endtask

  task automatic read_healths(input health_t exp_hl, input health_t exp_hr);
    apb_data_t rdata;
    apb_read(ADDR_HEALTH, 1'b0, rdata);
    check_health("health_l", rdata[HEALTH_L_LSB +: $bits(health_t)], exp_hl);
    check_health("health_r", rdata[HEALTH_R_LSB +: $bits(health_t)], exp_hr);
  endtask

  task automatic read_status(input logic ko_l, input logic ko_r);
    apb_data_t rdata;
    apb_data_t exp;
    exp = '0;
    exp[STATUS_KO_L_BIT] = ko_l;
    exp[STATUS_KO_R_BIT] = ko_r;
    apb_read(ADDR_STATUS, 1'b0, rdata);
    check_data("status", rdata, exp);
  endtask

  // ##########################################################################
  // stimulus and checking.
  // ##########################################################################

  initial begin
    apb_data_t rdata;
    coord_t    exp_l;
    coord_t    exp_r;
    health_t   exp_hl;
    health_t   exp_hr;
    health_t   dmg;
    int        dir_l;
    int        dir_r;
    int        k;
    int        n;
    seed = 32'hab39_d2c8;
    rst  = 1'b1;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {left_l, right_l, attack_l, left_r, right_r, attack_r} = 6'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;

    exp_l  = START_X_LEFT;
    exp_r  = START_X_RIGHT;
    exp_hl = HEALTH_FULL;
    exp_hr = HEALTH_FULL;
    apb_read(ADDR_CTRL, 1'b0, rdata);
    check_data("ctrl", rdata, CTRL_RESET);
    apb_read(ADDR_DAMAGE, 1'b0, rdata);
    check_data("damage", rdata, apb_data_t'(DAMAGE_RESET));
    read_healths(exp_hl, exp_hr);
    read_status(1'b0, 1'b0);
    read_positions(exp_l, exp_r);

    // swing from the start positions.
    hold_pads(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1);
    exp_hl = apply_damage(exp_hl, DAMAGE_RESET, boxes_overlap(exp_r, SIDE_RIGHT, exp_l));
    exp_hr = apply_damage(exp_hr, DAMAGE_RESET, boxes_overlap(exp_l, SIDE_LEFT, exp_r));
    read_healths(exp_hl, exp_hr);
    read_positions(exp_l, exp_r);

    for (n = 0; n < 6; n++) begin
      dir_l = $random(seed) & 3;
      dir_r = $random(seed) & 3;
      k     = 1 + ($random(seed) & 15);
      hold_pads(dir_l[0], dir_l[1], 1'b0, dir_r[0], dir_r[1], 1'b0, k);
      exp_l = step_position(exp_l, SIDE_LEFT, dir_l[0], dir_l[1], k);
      exp_r = step_position(exp_r, SIDE_RIGHT, dir_r[0], dir_r[1], k);
      read_positions(exp_l, exp_r);
    end

    // back both players into the walls.
    hold_pads(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 250);
    exp_l = step_position(exp_l, SIDE_LEFT, 1'b1, 1'b0, 250);
    exp_r = step_position(exp_r, SIDE_RIGHT, 1'b0, 1'b1, 250);
    read_positions(exp_l, exp_r);

    // walk into reach of each other.
    hold_pads(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 70);
    exp_l = step_position(exp_l, SIDE_LEFT, 1'b0, 1'b1, 70);
    exp_r = step_position(exp_r, SIDE_RIGHT, 1'b1, 1'b0, 70);
    read_positions(exp_l, exp_r);

    // odd and no divisor of 100, so the last blow saturates.
    dmg = health_t'(7 + 2 * ($random(seed) & 7));
    apb_write(ADDR_DAMAGE, apb_data_t'(dmg), 1'b0);
    apb_read(ADDR_DAMAGE, 1'b0, rdata);
    check_data("damage", rdata, apb_data_t'(dmg));
    for (n = 0; n < 30 && exp_hl != 0 && exp_hr != 0; n++) begin
      hold_pads(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1);
      exp_hl = apply_damage(exp_hl, dmg, boxes_overlap(exp_r, SIDE_RIGHT, exp_l));
      exp_hr = apply_damage(exp_hr, dmg, boxes_overlap(exp_l, SIDE_LEFT, exp_r));
      read_healths(exp_hl, exp_hr);
    end
    if (exp_hl != 0 && exp_hr != 0) report_failure("no knockout after 30 attacks");
    read_status(exp_hl == 0, exp_hr == 0);
    hold_pads(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 10);  // frozen after knockout.
    read_positions(exp_l, exp_r);

    apb_read(8'h20, 1'b1, rdata);
    apb_write(ADDR_HEALTH, 32'h0000_ffff, 1'b1);
    read_healths(exp_hl, exp_hr);
    apb_read(ADDR_DAMAGE, 1'b0, rdata);
    check_data("damage", rdata, apb_data_t'(dmg));
    apb_write(ADDR_CTRL, 32'h0000_0003, 1'b0);
    exp_hl = HEALTH_FULL;
    exp_hr = HEALTH_FULL;
    read_healths(exp_hl, exp_hr);
    read_status(1'b0, 1'b0);
    apb_read(ADDR_CTRL, 1'b0, rdata);
    check_data("ctrl", rdata, 32'h0000_0001);
    hold_pads(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 5);
    exp_l = step_position(exp_l, SIDE_LEFT, 1'b1, 1'b0, 5);
    exp_r = step_position(exp_r, SIDE_RIGHT, 1'b0, 1'b1, 5);
    read_positions(exp_l, exp_r);

    $display("all tests passed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+verif
common/fight_pkg.sv
common/fight_regs_pkg.sv
player/player.sv
logic/hit_detect.sv
logic/health_keeper.sv
logic/fight_regs.sv
logic/fight_top.sv
verif/fight_tb.sv

// ==== Bender.yml ====
package:
  name: fight_core

sources:
  - common/fight_pkg.sv
  - common/fight_regs_pkg.sv
  - player/player.sv
  - logic/hit_detect.sv
  - logic/health_keeper.sv
  - logic/fight_regs.sv
  - logic/fight_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/fight_tb.sv
